/* rf_pkg.sv */
`default_nettype none

package rf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word and address widths
    ////////////////////////////////////////////////////////////////////////////

    // One register-file word
    localparam int RF_DATA_W = 64;

    // Host address, store plus mapped I/O
    localparam int RF_ADDR_W = 10;

    // Store occupies the low half of the address space
    localparam int STORE_ADDR_W = 9;
    localparam int STORE_DEPTH = 2 ** STORE_ADDR_W;

    typedef logic [RF_DATA_W-1:0] rf_data_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [STORE_ADDR_W-1:0] store_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Mapped I/O windows, four lanes each
    ////////////////////////////////////////////////////////////////////////////

    // Square unit, X loads a lane
    localparam rf_addr_t ADDR_SQ_X_BASE = 10'h200;

    // Square unit, Y returns a lane result
    localparam rf_addr_t ADDR_SQ_Y_BASE = 10'h208;

    // Center unit inputs
    localparam rf_addr_t ADDR_CT_X_BASE = 10'h210;

    // Center unit results
    localparam rf_addr_t ADDR_CT_Y_BASE = 10'h218;

    // Remaining I/O space stays unmapped
    // Writes dropped, reads return zero

endpackage

`default_nettype wire

/* eu_pkg.sv */
`default_nettype none

package eu_pkg;

    // Elements packed in one word
    localparam int ELEM_W = 16;
    localparam int N_ELEM = 4;

    // Lanes per unit and lane index width
    localparam int N_LANE = 4;
    localparam int LANE_IDX_W = 2;

    // Full product of two elements
    localparam int PROD_W = 2 * ELEM_W;

    // Divide by N_ELEM as a right shift
    localparam int MEAN_SHIFT = 2;
    localparam int SUM_W = ELEM_W + MEAN_SHIFT;

    typedef logic [N_LANE-1:0] lane_sel_t;
    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

/* host_req_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_req_port (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req,
    input  wire                     we,
    input  wire rf_pkg::rf_addr_t   addr,
    input  wire rf_pkg::rf_data_t   wdata,
    output logic                    acc_re,
    output logic                    acc_we,
    output rf_pkg::rf_addr_t        acc_addr,
    output rf_pkg::rf_data_t        acc_wdata
);

    // Armed, or waiting for the host to drop req
    typedef enum logic {
        IDLE,
        WAIT_LOW
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            acc_re <= 1'b0;
            acc_we <= 1'b0;
        end else begin
            // Strobes last one cycle only
            acc_re <= 1'b0;
            acc_we <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        acc_re <= !we;
                        acc_we <= we;
                        state  <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    // Rearm once the handshake closes
                    if (!req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data captured along with the strobe
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            acc_addr  <= addr;
            acc_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

/* rf_store.sv */
`timescale 1ns/1ps
`default_nettype none

module rf_store (
    input  wire                         clk,
    input  wire                         st_re,
    input  wire                         st_we,
    input  wire rf_pkg::store_addr_t    st_addr,
    input  wire rf_pkg::rf_data_t       st_wdata,
    output rf_pkg::rf_data_t            st_q
);

    // Inferred single-port RAM
    rf_pkg::rf_data_t mem [rf_pkg::STORE_DEPTH];

    always_ff @(posedge clk) begin
        if (st_we) begin
            mem[st_addr] <= st_wdata;
        end
        // Output register holds between reads
        if (st_re) begin
            st_q <= mem[st_addr];
        end
    end

endmodule

`default_nettype wire

/* rf_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module rf_ram (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         acc_re,
    input  wire                         acc_we,
    input  wire rf_pkg::rf_addr_t       acc_addr,
    input  wire rf_pkg::rf_data_t       acc_wdata,
    output logic                        rd_valid,
    output logic                        wr_done,
    output rf_pkg::rf_data_t            rd_data,
    // Store side
    output logic                        st_re,
    output logic                        st_we,
    output rf_pkg::store_addr_t         st_addr,
    output rf_pkg::rf_data_t            st_wdata,
    input  wire rf_pkg::rf_data_t       st_q,
    // Square unit
    output eu_pkg::lane_sel_t           sq_x_we,
    output eu_pkg::lane_sel_t           sq_y_re,
    input  wire rf_pkg::rf_data_t       sq_y_data,
    // Center unit
    output eu_pkg::lane_sel_t           ct_x_we,
    output eu_pkg::lane_sel_t           ct_y_re,
    input  wire rf_pkg::rf_data_t       ct_y_data,
    // Shared by both units
    output rf_pkg::rf_data_t            x_data
);

    // True when addr falls in the four-lane window at base
    function automatic logic in_window(rf_pkg::rf_addr_t a, rf_pkg::rf_addr_t base);
        return a[rf_pkg::RF_ADDR_W-1:eu_pkg::LANE_IDX_W]
            == base[rf_pkg::RF_ADDR_W-1:eu_pkg::LANE_IDX_W];
    endfunction

    // Low address bits pick the lane
    function automatic eu_pkg::lane_sel_t lane_onehot(rf_pkg::rf_addr_t a);
        return eu_pkg::lane_sel_t'(1) << a[eu_pkg::LANE_IDX_W-1:0];
    endfunction

    logic              is_store;
    eu_pkg::lane_sel_t sq_x_sel;
    eu_pkg::lane_sel_t ct_x_sel;
    rf_pkg::rf_addr_t  addr_ff;

    // Store decodes only its own range, no aliasing into I/O
    assign is_store = acc_addr < rf_pkg::STORE_DEPTH;
    assign st_addr  = acc_addr[rf_pkg::STORE_ADDR_W-1:0];
    assign st_wdata = acc_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        st_we    = 1'b0;
        sq_x_sel = '0;
        ct_x_sel = '0;
        if (acc_we) begin
            if (is_store) begin
                st_we = 1'b1;
            end else if (in_window(acc_addr, rf_pkg::ADDR_SQ_X_BASE)) begin
                sq_x_sel = lane_onehot(acc_addr);
            end else if (in_window(acc_addr, rf_pkg::ADDR_CT_X_BASE)) begin
                ct_x_sel = lane_onehot(acc_addr);
            end
            // Unmapped I/O writes fall through
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        st_re   = 1'b0;
        sq_y_re = '0;
        ct_y_re = '0;
        if (acc_re) begin
            if (is_store) begin
                st_re = 1'b1;
            end else if (in_window(acc_addr, rf_pkg::ADDR_SQ_Y_BASE)) begin
                sq_y_re = lane_onehot(acc_addr);
            end else if (in_window(acc_addr, rf_pkg::ADDR_CT_Y_BASE)) begin
                ct_y_re = lane_onehot(acc_addr);
            end
        end
    end

    // X select and completion pulses, one cycle behind the strobe
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            sq_x_we  <= '0;
            ct_x_we  <= '0;
            rd_valid <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            sq_x_we  <= sq_x_sel;
            ct_x_we  <= ct_x_sel;
            rd_valid <= acc_re;
            wr_done  <= acc_we;
        end
    end

    // Write word and read address follow the store latency
    always_ff @(posedge clk) begin
        if (acc_we) x_data <= acc_wdata;
        if (acc_re) addr_ff <= acc_addr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data select on the delayed address
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (addr_ff < rf_pkg::STORE_DEPTH) begin
            rd_data = st_q;
        end else if (in_window(addr_ff, rf_pkg::ADDR_SQ_Y_BASE)) begin
            rd_data = sq_y_data;
        end else if (in_window(addr_ff, rf_pkg::ADDR_CT_Y_BASE)) begin
            rd_data = ct_y_data;
        end else begin
            // Unmapped I/O reads as zero
            rd_data = '0;
        end
    end

endmodule

`default_nettype wire

/* eu_square.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_square (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire eu_pkg::lane_sel_t      x_we,
    input  wire rf_pkg::rf_data_t       x_data,
    input  wire eu_pkg::lane_sel_t      y_re,
    output rf_pkg::rf_data_t            y_data
);

    rf_pkg::rf_data_t sq_word;
    rf_pkg::rf_data_t y_sel;
    rf_pkg::rf_data_t lane_res [eu_pkg::N_LANE];

    // High half of each unsigned square
    always_comb begin : square_elems
        eu_pkg::elem_t elem;
        eu_pkg::prod_t prod;
        sq_word = '0;
        for (int e = 0; e < eu_pkg::N_ELEM; e++) begin
            elem = x_data[e*eu_pkg::ELEM_W +: eu_pkg::ELEM_W];
            prod = elem * elem;
            sq_word[e*eu_pkg::ELEM_W +: eu_pkg::ELEM_W] =
                prod[eu_pkg::PROD_W-1 -: eu_pkg::ELEM_W];
        end
    end

    // Per-lane result registers
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < eu_pkg::N_LANE; l++) lane_res[l] <= '0;
        end else begin
            for (int l = 0; l < eu_pkg::N_LANE; l++) begin
                if (x_we[l]) lane_res[l] <= sq_word;
            end
        end
    end

    // One-hot lane pick
    always_comb begin
        y_sel = '0;
        for (int l = 0; l < eu_pkg::N_LANE; l++) begin
            if (y_re[l]) y_sel = y_sel | lane_res[l];
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) y_data <= '0;
        else if (|y_re) y_data <= y_sel;
    end

endmodule

`default_nettype wire

/* eu_center.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_center (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire eu_pkg::lane_sel_t      x_we,
    input  wire rf_pkg::rf_data_t       x_data,
    input  wire eu_pkg::lane_sel_t      y_re,
    output rf_pkg::rf_data_t            y_data
);

    eu_pkg::sum_t     elem_sum;
    eu_pkg::elem_t    mean;
    rf_pkg::rf_data_t ct_word;
    rf_pkg::rf_data_t y_sel;
    rf_pkg::rf_data_t lane_res [eu_pkg::N_LANE];

    ////////////////////////////////////////////////////////////////////////////
    // Mean removal
    ////////////////////////////////////////////////////////////////////////////

    // Sum carries two extra bits, no overflow
    always_comb begin
        elem_sum = '0;
        for (int e = 0; e < eu_pkg::N_ELEM; e++) begin
            elem_sum = elem_sum
                + eu_pkg::sum_t'(x_data[e*eu_pkg::ELEM_W +: eu_pkg::ELEM_W]);
        end
    end

    // Floor of the mean
    assign mean = eu_pkg::elem_t'(elem_sum >> eu_pkg::MEAN_SHIFT);

    // Subtract wraps at 16 bits
    always_comb begin
        ct_word = '0;
        for (int e = 0; e < eu_pkg::N_ELEM; e++) begin
            ct_word[e*eu_pkg::ELEM_W +: eu_pkg::ELEM_W] =
                x_data[e*eu_pkg::ELEM_W +: eu_pkg::ELEM_W] - mean;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < eu_pkg::N_LANE; l++) lane_res[l] <= '0;
        end else begin
            for (int l = 0; l < eu_pkg::N_LANE; l++) begin
                if (x_we[l]) lane_res[l] <= ct_word;
            end
        end
    end

    // Readback, same scheme as the square unit
    always_comb begin
        y_sel = '0;
        for (int l = 0; l < eu_pkg::N_LANE; l++) begin
            if (y_re[l]) y_sel = y_sel | lane_res[l];
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) y_data <= '0;
        else if (|y_re) y_data <= y_sel;
    end

endmodule

`default_nettype wire

/* host_rsp_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_rsp_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire                         rd_valid,
    input  wire                         wr_done,
    input  wire rf_pkg::rf_data_t       rd_data,
    output logic                        ack,
    output rf_pkg::rf_data_t            rdata
);

    // Waiting for completion, or holding ack
    typedef enum logic {
        IDLE,
        ACKED
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Response FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_valid) begin
                        rdata <= rd_data;
                        ack   <= 1'b1;
                        state <= ACKED;
                    end else if (wr_done) begin
                        // Writes answer with zero data
                        rdata <= '0;
                        ack   <= 1'b1;
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // Hold ack and data until req drops
                    if (!req) begin
                        ack   <= 1'b0;
                        rdata <= '0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rf_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire                         we,
    input  wire rf_pkg::rf_addr_t       addr,
    input  wire rf_pkg::rf_data_t       wdata,
    output logic                        ack,
    output rf_pkg::rf_data_t            rdata
);

    // Access strobe from the request side
    logic                acc_re;
    logic                acc_we;
    rf_pkg::rf_addr_t    acc_addr;
    rf_pkg::rf_data_t    acc_wdata;

    // Completion toward the response side
    logic                rd_valid;
    logic                wr_done;
    rf_pkg::rf_data_t    rd_data;

    // Store
    logic                st_re;
    logic                st_we;
    rf_pkg::store_addr_t st_addr;
    rf_pkg::rf_data_t    st_wdata;
    rf_pkg::rf_data_t    st_q;

    // Execution units
    eu_pkg::lane_sel_t   sq_x_we;
    eu_pkg::lane_sel_t   sq_y_re;
    rf_pkg::rf_data_t    sq_y_data;
    eu_pkg::lane_sel_t   ct_x_we;
    eu_pkg::lane_sel_t   ct_y_re;
    rf_pkg::rf_data_t    ct_y_data;
    rf_pkg::rf_data_t    x_data;

    host_req_port u_req (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .acc_re    (acc_re),
        .acc_we    (acc_we),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata)
    );

    rf_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_re    (acc_re),
        .acc_we    (acc_we),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .rd_valid  (rd_valid),
        .wr_done   (wr_done),
        .rd_data   (rd_data),
        .st_re     (st_re),
        .st_we     (st_we),
        .st_addr   (st_addr),
        .st_wdata  (st_wdata),
        .st_q      (st_q),
        .sq_x_we   (sq_x_we),
        .sq_y_re   (sq_y_re),
        .sq_y_data (sq_y_data),
        .ct_x_we   (ct_x_we),
        .ct_y_re   (ct_y_re),
        .ct_y_data (ct_y_data),
        .x_data    (x_data)
    );

    rf_store u_store (
        .clk      (clk),
        .st_re    (st_re),
        .st_we    (st_we),
        .st_addr  (st_addr),
        .st_wdata (st_wdata),
        .st_q     (st_q)
    );

    eu_square u_square (
        .clk    (clk),
        .rst_n  (rst_n),
        .x_we   (sq_x_we),
        .x_data (x_data),
        .y_re   (sq_y_re),
        .y_data (sq_y_data)
    );

    eu_center u_center (
        .clk    (clk),
        .rst_n  (rst_n),
        .x_we   (ct_x_we),
        .x_data (x_data),
        .y_re   (ct_y_re),
        .y_data (ct_y_data)
    );

    host_rsp_port u_rsp (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rd_valid (rd_valid),
        .wr_done  (wr_done),
        .rd_data  (rd_data),
        .ack      (ack),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

/* tb_rf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rf_top;

    // Store transfers per direction
    localparam int N_STORE = 64;

    // Reset reads, store, square, center, overwrite, unmapped
    localparam int N_XFERS = 8 + 2 * N_STORE + 8 + 16 + 10 + 12;
    localparam int CYCLE_LIMIT = N_XFERS * 20;

    logic             clk;
    logic             rst_n;
    logic             req;
    logic             we;
    rf_pkg::rf_addr_t addr;
    rf_pkg::rf_data_t wdata;
    logic             ack;
    rf_pkg::rf_data_t rdata;

    // Shadow models of the store and the last X word per lane
    rf_pkg::rf_data_t store_shadow [rf_pkg::STORE_DEPTH];
    rf_pkg::rf_data_t sq_x [eu_pkg::N_LANE];
    rf_pkg::rf_data_t ct_x [eu_pkg::N_LANE];

    // Expected responses in issue order
    rf_pkg::rf_data_t exp_q [$];
    string            name_q [$];

    int err_count;
    int check_count;
    int tests_run;
    int cycle_count;

    rf_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic lane_window_hit(rf_pkg::rf_addr_t a, rf_pkg::rf_addr_t base);
        return (a >= base) && (a < base + eu_pkg::N_LANE);
    endfunction

    // Expected Y word for an I/O address, given the lane's last X word
    function automatic rf_pkg::rf_data_t expected_y(rf_pkg::rf_addr_t a,
                                                    rf_pkg::rf_data_t x);
        rf_pkg::rf_data_t res;
        logic [31:0]      sq;
        logic [17:0]      sum;
        logic [15:0]      mean;
        res = '0;
        if (lane_window_hit(a, rf_pkg::ADDR_SQ_Y_BASE)) begin
            // Upper half of the unsigned square
            for (int e = 0; e < 4; e++) begin
                sq = 32'(x[e*16 +: 16]) * 32'(x[e*16 +: 16]);
                res[e*16 +: 16] = sq[31:16];
            end
        end else if (lane_window_hit(a, rf_pkg::ADDR_CT_Y_BASE)) begin
            sum = '0;
            for (int e = 0; e < 4; e++) sum = sum + 18'(x[e*16 +: 16]);
            // Floor of the mean, then wrapping subtract
            mean = sum[17:2];
            for (int e = 0; e < 4; e++) res[e*16 +: 16] = x[e*16 +: 16] - mean;
        end
        return res;
    endfunction

    function automatic rf_pkg::rf_data_t expected_read(rf_pkg::rf_addr_t a);
        if (a < rf_pkg::STORE_DEPTH) return store_shadow[a[8:0]];
        if (lane_window_hit(a, rf_pkg::ADDR_SQ_Y_BASE)) return expected_y(a, sq_x[a[1:0]]);
        if (lane_window_hit(a, rf_pkg::ADDR_CT_Y_BASE)) return expected_y(a, ct_x[a[1:0]]);
        return expected_y(a, '0);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Host driver
    ////////////////////////////////////////////////////////////////////////////

    // One four-phase handshake
    task automatic transfer(input logic w, input rf_pkg::rf_addr_t a,
                            input rf_pkg::rf_data_t d);
        @(posedge clk);
        req   <= 1'b1;
        we    <= w;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        while (!ack) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    task automatic write_word(input rf_pkg::rf_addr_t a, input rf_pkg::rf_data_t d);
        if (a < rf_pkg::STORE_DEPTH) store_shadow[a[8:0]] = d;
        else if (lane_window_hit(a, rf_pkg::ADDR_SQ_X_BASE)) sq_x[a[1:0]] = d;
        else if (lane_window_hit(a, rf_pkg::ADDR_CT_X_BASE)) ct_x[a[1:0]] = d;
        // Write acks carry zero data
        exp_q.push_back('0);
        name_q.push_back($sformatf("rdata(wr %03h)", a));
        transfer(1'b1, a, d);
    endtask

    task automatic read_word(input rf_pkg::rf_addr_t a);
        exp_q.push_back(expected_read(a));
        name_q.push_back($sformatf("rdata(rd %03h)", a));
        transfer(1'b0, a, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input rf_pkg::rf_data_t got,
                               input rf_pkg::rf_data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Compare on each rising ack
    initial begin : compare_responses
        logic             ack_seen;
        rf_pkg::rf_data_t exp;
        string            name;
        ack_seen = 1'b0;
        forever begin
            @(posedge clk);
            if (ack === 1'b1 && !ack_seen) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("Error at %0t ns: ack rose with no transfer outstanding", $time);
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_value(name, rdata, exp);
                end
            end
            ack_seen = (ack === 1'b1);
        end
    end

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("%-10s errors %0d", name, err_count - errs_before);
    endtask

    // Guard against a stalled handshake
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Handshake stalled: run stopped after %0d cycles", cycle_count);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run_tests
        int               errs_before;
        rf_pkg::rf_data_t w;
        rf_pkg::rf_addr_t st_addrs [N_STORE];
        rf_pkg::rf_addr_t unmapped [5];
        void'($urandom(4202));
        err_count   = 0;
        check_count = 0;
        tests_run   = 0;
        for (int l = 0; l < eu_pkg::N_LANE; l++) begin
            sq_x[l] = '0;
            ct_x[l] = '0;
        end
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Every lane result reads zero out of reset
        errs_before = err_count;
        for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_SQ_Y_BASE + l);
        for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_CT_Y_BASE + l);
        report_test("reset", errs_before);

        errs_before = err_count;
        for (int i = 0; i < N_STORE; i++) begin
            st_addrs[i] = rf_pkg::rf_addr_t'($urandom_range(0, rf_pkg::STORE_DEPTH - 1));
            write_word(st_addrs[i], {$urandom, $urandom});
        end
        for (int i = 0; i < N_STORE; i++) read_word(st_addrs[i]);
        report_test("store", errs_before);

        errs_before = err_count;
        for (int l = 0; l < 4; l++) write_word(rf_pkg::ADDR_SQ_X_BASE + l, {$urandom, $urandom});
        for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_SQ_Y_BASE + l);
        report_test("square", errs_before);

        // Second round forces every element high, sums past 16 bits
        errs_before = err_count;
        for (int r = 0; r < 2; r++) begin
            for (int l = 0; l < 4; l++) begin
                w = {$urandom, $urandom};
                if (r == 1) w = w | 64'h8000_8000_8000_8000;
                if (r == 0 && l == 0) w = 64'hffff_fffe_8001_7fff;
                write_word(rf_pkg::ADDR_CT_X_BASE + l, w);
            end
            for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_CT_Y_BASE + l);
        end
        report_test("center", errs_before);

        // One lane per unit rewritten, the others must hold
        errs_before = err_count;
        write_word(rf_pkg::ADDR_SQ_X_BASE + 2, {$urandom, $urandom});
        write_word(rf_pkg::ADDR_CT_X_BASE + 1, {$urandom, $urandom});
        for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_SQ_Y_BASE + l);
        for (int l = 0; l < 4; l++) read_word(rf_pkg::ADDR_CT_Y_BASE + l);
        report_test("lanes", errs_before);

        // SiLU and attention windows, plus the alias of store word 0xf0
        errs_before = err_count;
        unmapped[0] = 10'h220;
        unmapped[1] = 10'h228;
        unmapped[2] = 10'h230;
        unmapped[3] = 10'h238;
        unmapped[4] = 10'h2f0;
        write_word(10'h0f0, {$urandom, $urandom});
        for (int i = 0; i < 5; i++) write_word(unmapped[i], {$urandom, $urandom});
        read_word(10'h0f0);
        for (int i = 0; i < 5; i++) read_word(unmapped[i]);
        report_test("unmapped", errs_before);

        if (exp_q.size() != 0) begin
            err_count++;
            $display("Error: %0d responses never arrived", exp_q.size());
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rf_pkg.sv
eu_pkg.sv
host_req_port.sv
rf_store.sv
rf_ram.sv
eu_square.sv
eu_center.sv
host_rsp_port.sv
rf_top.sv
tb_rf_top.sv

/* Bender.yml */
package:
  name: rf_vector

sources:
  - rf_pkg.sv
  - eu_pkg.sv
  - host_req_port.sv
  - rf_store.sv
  - rf_ram.sv
  - eu_square.sv
  - eu_center.sv
  - host_rsp_port.sv
  - rf_top.sv
  - target: test
    files:
      - tb_rf_top.sv
